// ==== rtl/uart_params.svh ====
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// Build-time defaults for the UART link.

// Clock cycles per serial bit, kept short for simulation.
`define UART_CLKS_PER_BIT 16

`define UART_BITS_N 8  // Data bits per frame.

`define UART_PARITY_TYPE 2  // 0 is none, 1 is odd, 2 is even.

`define UART_STAT_W 8  // Width of each statistics counter.

`endif

// ==== rtl/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

   // Parity mode of a frame.
   typedef enum logic [1:0] {
      par_none = 2'd0,  // No parity bit is sent.
      par_odd  = 2'd1,  // Parity bit makes the count of ones odd.
      par_even = 2'd2   // Parity bit makes the count of ones even.
   } parity_e;

   typedef enum logic [2:0] {
      tx_st_idle,    // Line high, waiting for a word.
      tx_st_start,   // Driving the start bit.
      tx_st_data,    // Driving the data bits, LSB first.
      tx_st_parity,  // Driving the parity bit.
      tx_st_stop     // Driving the stop bit.
   } tx_state_e;

   typedef enum logic [2:0] {
      rx_st_idle,    // Waiting for a low level on the line.
      rx_st_start,   // Confirming the start bit at mid-bit.
      rx_st_data,    // Sampling the data bits.
      rx_st_parity,  // Sampling the parity bit.
      rx_st_stop     // Sampling the stop bit.
   } rx_state_e;

endpackage

`default_nettype wire

// ==== rtl/uart_tx.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "uart_params.svh"

module uart_tx #(
   parameter int                CLKS_PER_BIT = `UART_CLKS_PER_BIT,
   parameter int                BITS_N       = `UART_BITS_N,
   parameter uart_pkg::parity_e PARITY_TYPE  = uart_pkg::parity_e'(`UART_PARITY_TYPE)
) (
   input  wire               clk,
   input  wire               rst,
   input  wire  [BITS_N-1:0] tx_data,
   input  wire               tx_valid,
   output logic              tx_ready,
   output logic              uart_out,
   output logic              tx_done
);
   import uart_pkg::*;

   localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
   localparam int IDX_W = (BITS_N > 1) ? $clog2(BITS_N) : 1;
   localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);
   localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(BITS_N - 1);

   tx_state_e         state;
   tx_state_e         state_nxt;
   logic [CNT_W-1:0]  baud_cnt;   // Cycles spent in the current bit.
   logic [IDX_W-1:0]  bit_idx;    // Index of the data bit on the line.
   logic [BITS_N-1:0] data_q;     // Word captured on acceptance.
   logic              baud_tick;
   logic              par_bit;
   logic              accept;

   assign tx_ready  = (state == tx_st_idle);  // Only an idle transmitter takes a word.
   assign accept    = tx_valid & tx_ready;
   assign baud_tick = (baud_cnt == LAST_CNT);  // Last cycle of the current bit.
   assign par_bit   = (PARITY_TYPE == par_odd) ? ~^data_q : ^data_q;
   assign tx_done   = (state == tx_st_stop) & baud_tick;  // Stop bit ends this cycle.

   always_comb begin
      state_nxt = state;
      case (state)
         tx_st_idle: begin
            if (accept) begin
               state_nxt = tx_st_start;
            end
         end
         tx_st_start: begin
            if (baud_tick) begin
               state_nxt = tx_st_data;
            end
         end
         tx_st_data: begin
            if (baud_tick && bit_idx == LAST_IDX) begin
               state_nxt = (PARITY_TYPE != par_none) ? tx_st_parity : tx_st_stop;
            end
         end
         tx_st_parity: begin
            if (baud_tick) begin
               state_nxt = tx_st_stop;
            end
         end
         tx_st_stop: begin
            if (baud_tick) begin
               state_nxt = tx_st_idle;
            end
         end
         default: state_nxt = tx_st_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst) begin
         state    <= tx_st_idle;
         baud_cnt <= '0;
         bit_idx  <= '0;
      end else begin
         state <= state_nxt;
         if (state == tx_st_idle || baud_tick) begin
            baud_cnt <= '0;  // The counter only runs while a frame is on the line.
         end else begin
            baud_cnt <= baud_cnt + 1'b1;
         end
         if (state != tx_st_data) begin
            bit_idx <= '0;
         end else if (baud_tick) begin
            bit_idx <= bit_idx + 1'b1;  // Next data bit at each bit boundary.
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         data_q <= tx_data;  // Holds the word stable for the whole frame.
      end
   end

   always_comb begin
      case (state)
         tx_st_start:  uart_out = 1'b0;             // The start bit is a zero.
         tx_st_data:   uart_out = data_q[bit_idx];
         tx_st_parity: uart_out = par_bit;
         default:      uart_out = 1'b1;             // Idle and stop keep the line high.
      endcase
   end

endmodule

`default_nettype wire

// ==== rtl/uart_rx.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "uart_params.svh"

module uart_rx #(
   parameter int                CLKS_PER_BIT = `UART_CLKS_PER_BIT,
   parameter int                BITS_N       = `UART_BITS_N,
   parameter uart_pkg::parity_e PARITY_TYPE  = uart_pkg::parity_e'(`UART_PARITY_TYPE)
) (
   input  wire               clk,
   input  wire               rst,
   input  wire               uart_in,
   output logic [BITS_N-1:0] rx_data,
   output logic              rx_valid,
   output logic              rx_parity_err,
   output logic              rx_frame_err
);
   import uart_pkg::*;

   localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
   localparam int IDX_W = (BITS_N > 1) ? $clog2(BITS_N) : 1;
   localparam int HALF  = (CLKS_PER_BIT > 1) ? CLKS_PER_BIT / 2 - 1 : 0;
   localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);
   localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(HALF);
   localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(BITS_N - 1);

   rx_state_e         state;
   logic [1:0]        sync_q;     // Two-flop synchronizer on the serial input.
   logic              line;
   logic              armed;      // Line has been high since the last frame.
   logic [CNT_W-1:0]  baud_cnt;
   logic [IDX_W-1:0]  bit_idx;
   logic [BITS_N-1:0] shreg;      // Data bits, shifted in from the top.
   logic              par_bit;    // Received parity bit.
   logic              baud_tick;
   logic              start_smp;
   logic              data_smp;
   logic              par_smp;
   logic              stop_smp;
   logic              par_exp;
   logic              par_mismatch;

   assign line      = sync_q[1];
   assign baud_tick = (baud_cnt == LAST_CNT);
   assign start_smp = (state == rx_st_start) & (baud_cnt == HALF_CNT);  // Mid start bit.
   assign data_smp  = (state == rx_st_data) & baud_tick;
   assign par_smp   = (state == rx_st_parity) & baud_tick;
   assign stop_smp  = (state == rx_st_stop) & baud_tick;

   // Parity recomputed from the received data and compared with the parity bit.
   assign par_exp      = (PARITY_TYPE == par_odd) ? ~^shreg : ^shreg;
   assign par_mismatch = (PARITY_TYPE != par_none) & (par_bit != par_exp);

   always_ff @(posedge clk) begin
      if (!rst) begin
         sync_q        <= 2'b11;  // The idle line is high.
         state         <= rx_st_idle;
         armed         <= 1'b0;
         baud_cnt      <= '0;
         bit_idx       <= '0;
         rx_valid      <= 1'b0;
         rx_parity_err <= 1'b0;
         rx_frame_err  <= 1'b0;
      end else begin
         sync_q   <= {sync_q[0], uart_in};
         rx_valid <= 1'b0;  // The result strobe lasts a single cycle.
         if (state == rx_st_idle || start_smp || baud_tick) begin
            baud_cnt <= '0;  // Each sample restarts the bit period.
         end else begin
            baud_cnt <= baud_cnt + 1'b1;
         end
         case (state)
            rx_st_idle: begin
               if (line) begin
                  armed <= 1'b1;
               end else if (armed) begin
                  state <= rx_st_start;  // A low level starts a frame.
               end
            end
            rx_st_start: begin
               if (start_smp) begin
                  bit_idx <= '0;
                  state   <= line ? rx_st_idle : rx_st_data;  // High again means a glitch.
               end
            end
            rx_st_data: begin
               if (data_smp) begin
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == LAST_IDX) begin
                     state <= (PARITY_TYPE != par_none) ? rx_st_parity : rx_st_stop;
                  end
               end
            end
            rx_st_parity: begin
               if (par_smp) begin
                  state <= rx_st_stop;
               end
            end
            rx_st_stop: begin
               if (stop_smp) begin
                  state         <= rx_st_idle;
                  armed         <= 1'b0;  // A low stop bit must end before a new start.
                  rx_valid      <= 1'b1;
                  rx_parity_err <= par_mismatch;
                  rx_frame_err  <= ~line;  // The stop bit has to be high.
               end
            end
            default: state <= rx_st_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (data_smp) begin
         shreg <= {line, shreg[BITS_N-1:1]};  // LSB first, so after BITS_N bits it sits at 0.
      end
      if (par_smp) begin
         par_bit <= line;
      end
      if (stop_smp) begin
         rx_data <= shreg;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/uart_link_stats.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "uart_params.svh"

module uart_link_stats (
   input  wire                     clk,
   input  wire                     rst,
   input  wire                     tx_done,
   input  wire                     rx_valid,
   input  wire                     rx_parity_err,
   input  wire                     rx_frame_err,
   output logic [`UART_STAT_W-1:0] tx_count,
   output logic [`UART_STAT_W-1:0] rx_count,
   output logic [`UART_STAT_W-1:0] parity_err_count,
   output logic [`UART_STAT_W-1:0] frame_err_count
);

   localparam int N_EVT = 4;
   localparam logic [`UART_STAT_W-1:0] CNT_MAX = '1;

   logic [N_EVT-1:0]                   evt;  // One event line per counter.
   logic [N_EVT-1:0][`UART_STAT_W-1:0] cnt;

   // Error flags only count together with the receive strobe.
   assign evt[0] = tx_done;
   assign evt[1] = rx_valid;
   assign evt[2] = rx_valid & rx_parity_err;
   assign evt[3] = rx_valid & rx_frame_err;

   always_ff @(posedge clk) begin
      if (!rst) begin
         cnt <= '0;
      end else begin
         for (int i = 0; i < N_EVT; i++) begin
            if (evt[i] && cnt[i] != CNT_MAX) begin
               cnt[i] <= cnt[i] + 1'b1;  // Counters stop at their maximum.
            end
         end
      end
   end

   assign tx_count         = cnt[0];
   assign rx_count         = cnt[1];
   assign parity_err_count = cnt[2];
   assign frame_err_count  = cnt[3];

endmodule

`default_nettype wire

// ==== rtl/uart_link.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "uart_params.svh"

module uart_link (
   input  wire                     clk,
   input  wire                     rst,
   input  wire  [`UART_BITS_N-1:0] tx_data,
   input  wire                     tx_valid,
   output logic                    tx_ready,
   output logic                    uart_out,
   input  wire                     uart_in,
   output logic [`UART_BITS_N-1:0] rx_data,
   output logic                    rx_valid,
   output logic                    rx_parity_err,
   output logic                    rx_frame_err,
   output logic [`UART_STAT_W-1:0] tx_count,
   output logic [`UART_STAT_W-1:0] rx_count,
   output logic [`UART_STAT_W-1:0] parity_err_count,
   output logic [`UART_STAT_W-1:0] frame_err_count
);
   import uart_pkg::*;

   logic tx_done;  // End of each sent frame, for the statistics.

   uart_tx #(
      .CLKS_PER_BIT (`UART_CLKS_PER_BIT),
      .BITS_N       (`UART_BITS_N),
      .PARITY_TYPE  (parity_e'(`UART_PARITY_TYPE))
   ) u_tx (
      .clk      (clk),
      .rst      (rst),
      .tx_data  (tx_data),
      .tx_valid (tx_valid),
      .tx_ready (tx_ready),
      .uart_out (uart_out),
      .tx_done  (tx_done)
   );

   // The receiver listens on its own input, which may or may not be looped back.
   uart_rx #(
      .CLKS_PER_BIT (`UART_CLKS_PER_BIT),
      .BITS_N       (`UART_BITS_N),
      .PARITY_TYPE  (parity_e'(`UART_PARITY_TYPE))
   ) u_rx (
      .clk           (clk),
      .rst           (rst),
      .uart_in       (uart_in),
      .rx_data       (rx_data),
      .rx_valid      (rx_valid),
      .rx_parity_err (rx_parity_err),
      .rx_frame_err  (rx_frame_err)
   );

   uart_link_stats u_stats (
      .clk              (clk),
      .rst              (rst),
      .tx_done          (tx_done),
      .rx_valid         (rx_valid),
      .rx_parity_err    (rx_parity_err),
      .rx_frame_err     (rx_frame_err),
      .tx_count         (tx_count),
      .rx_count         (rx_count),
      .parity_err_count (parity_err_count),
      .frame_err_count  (frame_err_count)
   );

endmodule

`default_nettype wire

// ==== test/uart_link_assert.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "uart_params.svh"

module uart_link_assert #(
   parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
   input wire                     clk,
   input wire                     rst,
   input var uart_pkg::tx_state_e tx_state,
   input wire                     tx_valid,
   input wire                     tx_ready,
   input wire                     uart_out,
   input wire                     tx_done,
   input wire                     rx_valid
);
   import uart_pkg::*;

   int fail_count = 0;  // Number of assertion failures in this instance.

   // Once a word is taken, the transmitter stays busy until its frame ends.
   tx_busy_not_ready: assert property (@(posedge clk) disable iff (!rst)
      (tx_valid || !tx_ready) && !tx_done |=> !tx_ready)
      else begin
         fail_count++;
         $error("tx_ready is high while the transmitter is busy");
      end

   // The start bit begins on the clock after acceptance and lasts one bit period.
   tx_start_low: assert property (@(posedge clk) disable iff (!rst)
      tx_state == tx_st_idle && tx_valid |=> (!uart_out) [*CLKS_PER_BIT])
      else begin
         fail_count++;
         $error("uart_out is not low for the whole start bit");
      end

   rx_strobe_single: assert property (@(posedge clk) disable iff (!rst)
      rx_valid |=> !rx_valid)
      else begin
         fail_count++;
         $error("rx_valid stayed high for more than one cycle");
      end

   tx_done_then_ready: assert property (@(posedge clk) disable iff (!rst)
      tx_done |=> tx_ready)
      else begin
         fail_count++;
         $error("tx_ready did not follow tx_done");
      end

endmodule

// The transmitter instance drives the tx side, the receiver instance the rx side.
bind uart_tx uart_link_assert #(
   .CLKS_PER_BIT (CLKS_PER_BIT)
) u_tx_assert (
   .clk      (clk),
   .rst      (rst),
   .tx_state (state),
   .tx_valid (tx_valid),
   .tx_ready (tx_ready),
   .uart_out (uart_out),
   .tx_done  (tx_done),
   .rx_valid (1'b0)
);

bind uart_rx uart_link_assert #(
   .CLKS_PER_BIT (CLKS_PER_BIT)
) u_rx_assert (
   .clk      (clk),
   .rst      (rst),
   .tx_state (uart_pkg::tx_st_idle),
   .tx_valid (1'b0),
   .tx_ready (1'b1),
   .uart_out (1'b1),
   .tx_done  (1'b0),
   .rx_valid (rx_valid)
);

`default_nettype wire

// ==== test/uart_link_checker.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "uart_params.svh"

module uart_link_checker (
   input wire                     clk,
   input wire                     rst,
   input wire                     rx_valid,
   input wire  [`UART_BITS_N-1:0] rx_data,
   input wire                     rx_parity_err,
   input wire                     rx_frame_err,
   input wire  [`UART_STAT_W-1:0] tx_count,
   input wire  [`UART_STAT_W-1:0] rx_count,
   input wire  [`UART_STAT_W-1:0] parity_err_count,
   input wire  [`UART_STAT_W-1:0] frame_err_count
);

   localparam int CNT_MAX = (1 << `UART_STAT_W) - 1;

   string                   name_q[$];  // Test name of each pending receive result.
   logic [`UART_BITS_N-1:0] data_q[$];
   logic                    pe_q[$];
   logic                    fe_q[$];
   int                      exp_tx    = 0;  // Expected event totals, before saturation.
   int                      exp_rx    = 0;
   int                      exp_pe    = 0;
   int                      exp_fe    = 0;
   int                      err_count = 0;

   function automatic int sat(input int v);
      return (v > CNT_MAX) ? CNT_MAX : v;  // The counters stick at their maximum.
   endfunction

   task automatic compare(input string name, input string what, input logic [31:0] expected,
                          input logic [31:0] actual);
      if (actual !== expected) begin
         $display("Fail %s %s: expected 0x%0h, got 0x%0h", name, what, expected, actual);
         err_count++;
      end
   endtask

   task automatic expect_frame(input string name, input logic [`UART_BITS_N-1:0] data,
                               input logic pe, input logic fe);
      name_q.push_back(name);
      data_q.push_back(data);
      pe_q.push_back(pe);
      fe_q.push_back(fe);
      exp_rx++;  // Every result counts once, errors add to their own counters.
      exp_pe += pe;
      exp_fe += fe;
   endtask

   task automatic expect_sent(input int n);
      exp_tx += n;
   endtask

   task automatic check_counts(input string name);
      compare(name, "tx_count", sat(exp_tx), tx_count);
      compare(name, "rx_count", sat(exp_rx), rx_count);
      compare(name, "parity_err_count", sat(exp_pe), parity_err_count);
      compare(name, "frame_err_count", sat(exp_fe), frame_err_count);
   endtask

   task automatic final_check();
      if (name_q.size() != 0) begin
         $display("%0d expected receive results never arrived", name_q.size());
         err_count += name_q.size();
      end
   endtask

   always @(posedge clk) begin : take_result
      string                   name;
      logic [`UART_BITS_N-1:0] data;
      logic                    pe;
      logic                    fe;
      if (rst && rx_valid) begin
         if (name_q.size() == 0) begin
            $display("Receive strobe with data 0x%0h came when no frame was due", rx_data);
            err_count++;
         end else begin
            name = name_q.pop_front();  // Results arrive in the order they were sent.
            data = data_q.pop_front();
            pe   = pe_q.pop_front();
            fe   = fe_q.pop_front();
            compare(name, "rx_data", data, rx_data);
            compare(name, "rx_parity_err", pe, rx_parity_err);
            compare(name, "rx_frame_err", fe, rx_frame_err);
         end
      end
   end

endmodule

`default_nettype wire

// ==== test/uart_link_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "uart_params.svh"

module uart_link_tb;
   import uart_pkg::*;

   localparam int CPB       = `UART_CLKS_PER_BIT;
   localparam int BITS_N    = `UART_BITS_N;
   localparam int FRAME_CYC = CPB * (BITS_N + 2 + ((`UART_PARITY_TYPE != 0) ? 1 : 0));
   localparam int LIMIT     = 3 * FRAME_CYC;  // Upper bound for any single wait.

   logic                    clk;
   logic                    rst;
   logic [BITS_N-1:0]       tx_data;
   logic                    tx_valid;
   logic                    tx_ready;
   logic                    uart_out;
   logic                    uart_line;
   logic [BITS_N-1:0]       rx_data;
   logic                    rx_valid;
   logic                    rx_parity_err;
   logic                    rx_frame_err;
   logic [`UART_STAT_W-1:0] tx_count;
   logic [`UART_STAT_W-1:0] rx_count;
   logic [`UART_STAT_W-1:0] parity_err_count;
   logic [`UART_STAT_W-1:0] frame_err_count;
   logic                    inj_sel;    // High while the testbench drives the receive line.
   logic                    inj_line;
   int                      rx_seen;    // Receive strobes seen so far.
   int                      wait_errs;  // Timeouts and other failures outside the checker.
   int                      seed;

   assign uart_line = inj_sel ? inj_line : uart_out;  // Loopback unless injecting.

   always #5 clk = ~clk;

   always @(posedge clk) begin
      if (rx_valid) begin
         rx_seen <= rx_seen + 1;
      end
   end

   uart_link u_dut (
      .clk              (clk),
      .rst              (rst),
      .tx_data          (tx_data),
      .tx_valid         (tx_valid),
      .tx_ready         (tx_ready),
      .uart_out         (uart_out),
      .uart_in          (uart_line),
      .rx_data          (rx_data),
      .rx_valid         (rx_valid),
      .rx_parity_err    (rx_parity_err),
      .rx_frame_err     (rx_frame_err),
      .tx_count         (tx_count),
      .rx_count         (rx_count),
      .parity_err_count (parity_err_count),
      .frame_err_count  (frame_err_count)
   );

   uart_link_checker u_chk (
      .clk              (clk),
      .rst              (rst),
      .rx_valid         (rx_valid),
      .rx_data          (rx_data),
      .rx_parity_err    (rx_parity_err),
      .rx_frame_err     (rx_frame_err),
      .tx_count         (tx_count),
      .rx_count         (rx_count),
      .parity_err_count (parity_err_count),
      .frame_err_count  (frame_err_count)
   );

   function automatic string op_label(input logic [7:0] op);
      case (op)
         8'h1:    return "loopback";
         8'h2:    return "back_to_back";
         8'h3:    return "bad_parity";
         8'h4:    return "low_stop";
         8'h5:    return "glitch";
         default: return "unknown";
      endcase
   endfunction

   task automatic wait_ready(input string name, input string what);
      int n;
      bit ok;
      ok = 1'b0;
      for (n = 0; n < LIMIT && !ok; n++) begin
         @(posedge clk);
         ok = tx_ready;  // Value before the edge, the one the DUT saw with tx_valid.
      end
      #1;
      if (!ok) begin
         $display("Timeout in %s: the transmitter did not %s", name, what);
         wait_errs++;
      end
   endtask

   task automatic wait_strobes(input string name, input int target);
      int n;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (rx_seen < target && n < LIMIT);
      #1;
      if (rx_seen < target) begin
         $display("Timeout in %s: the expected receive strobe never came", name);
         wait_errs++;
      end
   endtask

   task automatic send_bit(input logic b);
      inj_line = b;
      repeat (CPB) @(posedge clk);
      #1;
   endtask

   task automatic send_frame(input logic [BITS_N-1:0] data, input logic par, input logic stop);
      int i;
      send_bit(1'b0);  // Start bit.
      for (i = 0; i < BITS_N; i++) begin
         send_bit(data[i]);  // LSB first.
      end
      if (`UART_PARITY_TYPE != 0) begin
         send_bit(par);
      end
      send_bit(stop);
      inj_line = 1'b1;
   endtask

   task automatic run_line(input string name, input logic [7:0] op,
                           input logic [BITS_N-1:0] data, input logic [BITS_N-1:0] exp_data,
                           input logic pe, input logic fe);
      int start;
      start = rx_seen;
      case (op)
         8'h1: begin
            u_chk.expect_frame(name, exp_data, pe, fe);
            u_chk.expect_sent(1);
            tx_data  = data;
            tx_valid = 1'b1;
            wait_ready(name, "accept the word");
            tx_valid = 1'b0;
            wait_strobes(name, start + 1);
            wait_ready(name, "finish the frame");
         end
         8'h2: begin
            u_chk.expect_frame(name, data, 1'b0, 1'b0);
            u_chk.expect_frame(name, exp_data, pe, fe);
            u_chk.expect_sent(2);
            tx_data  = data;
            tx_valid = 1'b1;
            wait_ready(name, "accept the first word");
            tx_data = exp_data;  // Offered at once, while the first frame is on the line.
            wait_ready(name, "accept the second word");
            tx_valid = 1'b0;
            wait_strobes(name, start + 2);
            wait_ready(name, "finish the frame");
         end
         8'h3: begin
            u_chk.expect_frame(name, exp_data, pe, fe);
            inj_sel = 1'b1;
            send_frame(data, ~(^data), 1'b1);  // Parity bit inverted from the even rule.
            wait_strobes(name, start + 1);
            inj_sel = 1'b0;
         end
         8'h4: begin
            u_chk.expect_frame(name, exp_data, pe, fe);
            inj_sel = 1'b1;
            send_frame(data, ^data, 1'b0);
            wait_strobes(name, start + 1);
            inj_sel = 1'b0;
         end
         8'h5: begin
            inj_sel  = 1'b1;
            inj_line = 1'b0;  // Low for a quarter bit, shorter than the start check.
            repeat (CPB / 4) @(posedge clk);
            #1;
            inj_line = 1'b1;
            repeat (FRAME_CYC) @(posedge clk);
            #1;
            inj_sel = 1'b0;
         end
         default: begin
            $display("Unknown operation %0h in %s", op, name);
            wait_errs++;
         end
      endcase
      @(posedge clk);  // Counters follow their strobe by one cycle.
      #1;
      u_chk.check_counts(name);
   endtask

   initial begin
      int               fd;
      int               code;
      int               line_no;
      int               gap;
      int               afails;
      int               total;
      bit               done;
      logic [7:0]       f_op;
      logic [7:0]       f_data;
      logic [7:0]       f_exp;
      logic [7:0]       f_pe;
      logic [7:0]       f_fe;
      logic [8*160-1:0] skip;
      string            name;
      clk       = 1'b0;
      rst       = 1'b0;
      tx_data   = '0;
      tx_valid  = 1'b0;
      inj_sel   = 1'b0;
      inj_line  = 1'b1;
      rx_seen   = 0;
      wait_errs = 0;
      seed      = 24;
      line_no   = 0;
      done      = 1'b0;
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b1;
      repeat (2) @(posedge clk);
      #1;
      fd = $fopen("test/uart_link_golden.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the golden file test/uart_link_golden.txt");
         wait_errs++;
         done = 1'b1;
      end
      while (!done) begin
         code = $fscanf(fd, "%h %h %h %h %h\n", f_op, f_data, f_exp, f_pe, f_fe);
         if (code == 5) begin
            line_no++;
            name = $sformatf("test%0d_%s", line_no, op_label(f_op));
            run_line(name, f_op, f_data[BITS_N-1:0], f_exp[BITS_N-1:0], f_pe[0], f_fe[0]);
            gap = $unsigned($random(seed)) % 4;  // Idle gap of 0 to 3 bit times.
            repeat (gap * CPB + 1) @(posedge clk);
            #1;
         end else if (code < 0 || $feof(fd)) begin
            done = 1'b1;
         end else begin
            code = $fgets(skip, fd);  // Comment line.
         end
      end
      if (fd != 0) begin
         $fclose(fd);
         if (line_no == 0) begin
            $display("The golden file holds no test lines");
            wait_errs++;
         end
      end
      u_chk.final_check();
      afails = u_dut.u_tx.u_tx_assert.fail_count + u_dut.u_rx.u_rx_assert.fail_count;
      total  = u_chk.err_count + wait_errs + afails;
      $display("Mismatches: %0d, other failures: %0d, assertion failures: %0d",
               u_chk.err_count, wait_errs, afails);
      if (total == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== test/uart_link_golden.txt ====
# op: 1 loopback, 2 two words back to back, 3 bad parity, 4 low stop bit, 5 glitch
# op data exp_data exp_parity_err exp_frame_err (all hex)
1 00 00 0 0
1 ff ff 0 0
1 55 55 0 0
1 a5 a5 0 0
1 01 01 0 0
1 02 02 0 0
1 04 04 0 0
1 08 08 0 0
1 10 10 0 0
1 20 20 0 0
1 40 40 0 0
1 80 80 0 0
2 3c c3 0 0
3 5a 5a 1 0
4 96 96 0 1
5 00 00 0 0

// ==== list.f ====
+incdir+rtl
rtl/uart_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_link_stats.sv
rtl/uart_link.sv
test/uart_link_assert.sv
test/uart_link_checker.sv
test/uart_link_tb.sv

// ==== Bender.yml ====
package:
  name: uart_link

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/uart_pkg.sv
      - rtl/uart_tx.sv
      - rtl/uart_rx.sv
      - rtl/uart_link_stats.sv
      - rtl/uart_link.sv
  - target: test
    files:
      - test/uart_link_assert.sv
      - test/uart_link_checker.sv
      - test/uart_link_tb.sv
